//--- verilog/soc_bus_pkg.sv
package soc_bus_pkg;

  // System bus widths
  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_word_t;
  typedef logic [3:0]  byte_mask_t;

  // Top nibble of the accelerator region
  localparam logic [3:0] GEMM_REGION = 4'h9;

  // Accelerator register offsets, one word each
  localparam logic [7:0] CTRL_OFS   = 8'h00;
  localparam logic [7:0] STATUS_OFS = 8'h04;
  localparam logic [7:0] A_ADDR_OFS = 8'h08;
  localparam logic [7:0] B_ADDR_OFS = 8'h0c;
  localparam logic [7:0] C_ADDR_OFS = 8'h10;
  localparam logic [7:0] DISP_OFS   = 8'h14;

  // CTRL and STATUS bit positions
  localparam int CTRL_START_BIT  = 0;
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

endpackage

//--- verilog/gemm_pkg.sv
package gemm_pkg;

  // Matrix side length
  localparam int mat_dim = 4;

  // Signed input element and signed result element
  typedef logic signed [7:0]  elem_t;
  typedef logic signed [31:0] acc_t;

  // One memory line: 16 elements or 4 results
  typedef logic [127:0] line_t;

  // Controller sequence
  typedef enum logic [2:0] {
    IDLE,
    READ_A,
    READ_B,
    ROW,
    DONE
  } gemm_state_t;

endpackage

//--- verilog/bus_router.sv
`timescale 1ns/1ps

module bus_router
  import soc_bus_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      bus_en,
  input  bus_addr_t bus_addr,
  input  bus_word_t mem_rd_data,
  input  bus_word_t regs_rd_data,
  output logic      mem_en,
  output logic      regs_en,
  output bus_word_t bus_rd_data
);

  logic is_gemm;
  logic regs_sel_q; // Target of the last access

  assign is_gemm = (bus_addr[31:28] == GEMM_REGION);
  assign mem_en  = bus_en && !is_gemm;
  assign regs_en = bus_en && is_gemm;

  always_ff @(posedge clk) begin
    if (rst) begin
      regs_sel_q <= 1'b0;
    end else if (bus_en) begin
      regs_sel_q <= is_gemm;
    end
  end

  // Data returns one cycle after the strobe
  assign bus_rd_data = regs_sel_q ? regs_rd_data : mem_rd_data;

endmodule

//--- verilog/banked_mem.sv
`timescale 1ns/1ps

module banked_mem
  import soc_bus_pkg::*, gemm_pkg::*;
#(
  parameter int NUM_RAMS = 16,
  parameter int A_WID    = 9,
  parameter int D_WID    = 8
) (
  input  logic             clk,
  input  logic             bus_en,
  input  logic             bus_rdwr,
  input  byte_mask_t       bus_mask,
  input  bus_addr_t        bus_addr,
  input  bus_word_t        bus_wr_data,
  output bus_word_t        bus_rd_data,
  input  logic             line_en,
  input  logic             line_rdwr,
  input  logic [A_WID-1:0] line_addr,
  input  line_t            line_wr_data,
  output line_t            line_rd_data
);

  localparam int LANES = 4; // Banks per bus word

  logic [A_WID-1:0]                     bus_idx;
  logic [1:0]                           bus_grp;
  logic [1:0]                           bus_grp_q;
  logic [NUM_RAMS-1:0][D_WID-1:0]       bank_rd;

  assign bus_idx = bus_addr[A_WID+3:4];
  assign bus_grp = bus_addr[3:2];

  for (genvar r = 0; r < NUM_RAMS; r++) begin : g_bank
    localparam int LANE = r % LANES;
    localparam int GRP  = r / LANES;

    logic [D_WID-1:0] ram [2**A_WID];
    logic [D_WID-1:0] bus_q;
    logic [D_WID-1:0] line_q;
    logic             bus_hit;

    assign bus_hit = bus_en && (bus_grp == GRP[1:0]);

    always_ff @(posedge clk) begin
      if (bus_hit && bus_rdwr && bus_mask[LANE]) begin
        ram[bus_idx] <= bus_wr_data[D_WID*LANE +: D_WID];
      end
      if (line_en && line_rdwr) begin
        ram[line_addr] <= line_wr_data[D_WID*r +: D_WID];
      end
      if (bus_hit && !bus_rdwr) begin
        bus_q <= ram[bus_idx];
      end
      if (line_en && !line_rdwr) begin
        line_q <= ram[line_addr]; // Held across line writes
      end
    end

    assign bank_rd[r]                       = bus_q;
    assign line_rd_data[D_WID*r +: D_WID]   = line_q;
  end

  always_ff @(posedge clk) begin
    if (bus_en && !bus_rdwr) begin
      bus_grp_q <= bus_grp;
    end
  end

  assign bus_rd_data = bank_rd[LANES*bus_grp_q +: LANES];

endmodule

//--- verilog/gemm_regs.sv
`timescale 1ns/1ps

module gemm_regs
  import soc_bus_pkg::*;
#(
  parameter int A_WID = 9
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             regs_en,
  input  logic             bus_rdwr,
  input  bus_addr_t        bus_addr,
  input  bus_word_t        bus_wr_data,
  output bus_word_t        regs_rd_data,
  output logic             start,
  output logic [A_WID-1:0] a_addr,
  output logic [A_WID-1:0] b_addr,
  output logic [A_WID-1:0] c_addr,
  output bus_word_t        disp_value,
  input  logic             busy,
  input  logic             done
);

  logic [7:0] ofs;
  logic       wr;
  bus_word_t  a_reg, b_reg, c_reg, disp_reg;
  bus_word_t  status;

  assign ofs = bus_addr[7:0];
  assign wr  = regs_en && bus_rdwr;

  // One-cycle pulse, dropped while a run is in progress
  assign start = wr && (ofs == CTRL_OFS) && bus_wr_data[CTRL_START_BIT] && !busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      disp_reg <= '0;
    end else if (wr && ofs == DISP_OFS) begin
      disp_reg <= bus_wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (wr && ofs == A_ADDR_OFS) a_reg <= bus_wr_data;
    if (wr && ofs == B_ADDR_OFS) b_reg <= bus_wr_data;
    if (wr && ofs == C_ADDR_OFS) c_reg <= bus_wr_data;
  end

  always_comb begin
    status = '0;
    status[STATUS_BUSY_BIT] = busy;
    status[STATUS_DONE_BIT] = done;
  end

  always_ff @(posedge clk) begin
    if (regs_en && !bus_rdwr) begin
      case (ofs)
        STATUS_OFS: regs_rd_data <= status;
        A_ADDR_OFS: regs_rd_data <= a_reg;
        B_ADDR_OFS: regs_rd_data <= b_reg;
        C_ADDR_OFS: regs_rd_data <= c_reg;
        DISP_OFS:   regs_rd_data <= disp_reg;
        default:    regs_rd_data <= '0; // CTRL reads as zero
      endcase
    end
  end

  // Byte addresses down to line addresses
  assign a_addr     = a_reg[A_WID+3:4];
  assign b_addr     = b_reg[A_WID+3:4];
  assign c_addr     = c_reg[A_WID+3:4];
  assign disp_value = disp_reg;

endmodule

//--- verilog/gemm_row_mac.sv
`timescale 1ns/1ps

module gemm_row_mac
  import gemm_pkg::*;
(
  input  elem_t [mat_dim-1:0] a_row,
  input  line_t               b_mat,
  output line_t               c_row
);

  always_comb begin
    acc_t  sum;
    elem_t b_elem;
    c_row = '0;
    for (int j = 0; j < mat_dim; j++) begin
      sum = '0;
      for (int k = 0; k < mat_dim; k++) begin
        b_elem = elem_t'(b_mat[8*(mat_dim*k + j) +: 8]); // B[k][j]
        sum    = sum + acc_t'(a_row[k]) * acc_t'(b_elem);
      end
      c_row[32*j +: 32] = sum;
    end
  end

endmodule

//--- verilog/gemm_ctrl.sv
`timescale 1ns/1ps

module gemm_ctrl
  import gemm_pkg::*;
#(
  parameter int A_WID = 9
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  logic [A_WID-1:0] a_addr,
  input  logic [A_WID-1:0] b_addr,
  input  logic [A_WID-1:0] c_addr,
  output logic             busy,
  output logic             done,
  output logic             line_en,
  output logic             line_rdwr,
  output logic [A_WID-1:0] line_addr,
  output line_t            line_wr_data,
  input  line_t            line_rd_data
);

  localparam int ROW_W = $clog2(mat_dim);
  localparam int ROW_BITS = mat_dim * 8;

  gemm_state_t             state_q, state_d;
  logic [ROW_W-1:0]        row_q;
  line_t                   a_line, b_line;
  line_t                   b_mat;
  elem_t [mat_dim-1:0]     a_row;
  line_t                   c_row;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start) state_d = READ_A;
      READ_A:  state_d = READ_B;
      READ_B:  state_d = ROW;
      ROW:     if (row_q == ROW_W'(mat_dim - 1)) state_d = DONE;
      DONE:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      row_q   <= '0;
      done    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == ROW) row_q <= row_q + 1'b1;
      else                row_q <= '0;
      if (state_q == IDLE && start) done <= 1'b0;
      else if (state_q == DONE)     done <= 1'b1;
    end
  end

  // A arrives during READ_B, B during the first row
  always_ff @(posedge clk) begin
    if (state_q == READ_B) a_line <= line_rd_data;
    if (state_q == ROW && row_q == '0) b_line <= line_rd_data;
  end

  assign b_mat = (row_q == '0) ? line_rd_data : b_line;
  assign a_row = a_line[ROW_BITS*row_q +: ROW_BITS];

  gemm_row_mac u_mac (
    .a_row (a_row),
    .b_mat (b_mat),
    .c_row (c_row)
  );

  always_comb begin
    line_en   = 1'b0;
    line_rdwr = 1'b0;
    line_addr = a_addr;
    case (state_q)
      READ_A: line_en = 1'b1;
      READ_B: begin
        line_en   = 1'b1;
        line_addr = b_addr;
      end
      ROW: begin
        line_en   = 1'b1;
        line_rdwr = 1'b1;
        line_addr = c_addr + A_WID'(row_q); // Row i goes to C plus i
      end
      default: ;
    endcase
  end

  assign line_wr_data = c_row;
  assign busy         = (state_q != IDLE);

endmodule

//--- verilog/sevseg_scan.sv
`timescale 1ns/1ps

module sevseg_scan
  import soc_bus_pkg::*;
#(
  parameter int SCAN_BITS = 16
) (
  input  logic       clk,
  input  logic       rst,
  input  bus_word_t  value,
  output logic [7:0] an,
  output logic [6:0] a_to_g
);

  logic [SCAN_BITS+2:0] cnt;
  logic [2:0]           digit;
  logic [3:0]           nibble;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign digit  = cnt[SCAN_BITS+2:SCAN_BITS]; // Top bits pick the digit
  assign nibble = value[4*digit +: 4];
  assign an     = ~(8'b1 << digit);

  // Segments a..g from bit 6 down, low is lit
  always_comb begin
    case (nibble)
      4'h0: a_to_g = 7'b0000001;
      4'h1: a_to_g = 7'b1001111;
      4'h2: a_to_g = 7'b0010010;
      4'h3: a_to_g = 7'b0000110;
      4'h4: a_to_g = 7'b1001100;
      4'h5: a_to_g = 7'b0100100;
      4'h6: a_to_g = 7'b0100000;
      4'h7: a_to_g = 7'b0001111;
      4'h8: a_to_g = 7'b0000000;
      4'h9: a_to_g = 7'b0000100;
      4'ha: a_to_g = 7'b0001000;
      4'hb: a_to_g = 7'b1100000;
      4'hc: a_to_g = 7'b0110001;
      4'hd: a_to_g = 7'b1000010;
      4'he: a_to_g = 7'b0110000;
      default: a_to_g = 7'b0111000;
    endcase
  end

endmodule

//--- verilog/gemm_soc.sv
`timescale 1ns/1ps

module gemm_soc
  import soc_bus_pkg::*, gemm_pkg::*;
#(
  parameter int NUM_RAMS  = 16,
  parameter int A_WID     = 9,
  parameter int D_WID     = 8,
  parameter int SCAN_BITS = 16
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       bus_en,
  input  logic       bus_rdwr,
  input  bus_addr_t  bus_addr,
  input  bus_word_t  bus_wr_data,
  input  byte_mask_t bus_mask,
  output bus_word_t  bus_rd_data,
  output logic [7:0] an,
  output logic [6:0] a_to_g
);

  logic             mem_en, regs_en;
  bus_word_t        mem_rd_data, regs_rd_data;
  bus_word_t        disp_value;
  logic             start, busy, done;
  logic [A_WID-1:0] a_addr, b_addr, c_addr;
  logic             line_en, line_rdwr;
  logic [A_WID-1:0] line_addr;
  line_t            line_wr_data, line_rd_data;

  bus_router u_router (
    .clk          (clk),
    .rst          (rst),
    .bus_en       (bus_en),
    .bus_addr     (bus_addr),
    .mem_rd_data  (mem_rd_data),
    .regs_rd_data (regs_rd_data),
    .mem_en       (mem_en),
    .regs_en      (regs_en),
    .bus_rd_data  (bus_rd_data)
  );

  banked_mem #(
    .NUM_RAMS (NUM_RAMS),
    .A_WID    (A_WID),
    .D_WID    (D_WID)
  ) u_mem (
    .clk          (clk),
    .bus_en       (mem_en),
    .bus_rdwr     (bus_rdwr),
    .bus_mask     (bus_mask),
    .bus_addr     (bus_addr),
    .bus_wr_data  (bus_wr_data),
    .bus_rd_data  (mem_rd_data),
    .line_en      (line_en),
    .line_rdwr    (line_rdwr),
    .line_addr    (line_addr),
    .line_wr_data (line_wr_data),
    .line_rd_data (line_rd_data)
  );

  gemm_regs #(.A_WID(A_WID)) u_regs (
    .clk          (clk),
    .rst          (rst),
    .regs_en      (regs_en),
    .bus_rdwr     (bus_rdwr),
    .bus_addr     (bus_addr),
    .bus_wr_data  (bus_wr_data),
    .regs_rd_data (regs_rd_data),
    .start        (start),
    .a_addr       (a_addr),
    .b_addr       (b_addr),
    .c_addr       (c_addr),
    .disp_value   (disp_value),
    .busy         (busy),
    .done         (done)
  );

  gemm_ctrl #(.A_WID(A_WID)) u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .a_addr       (a_addr),
    .b_addr       (b_addr),
    .c_addr       (c_addr),
    .busy         (busy),
    .done         (done),
    .line_en      (line_en),
    .line_rdwr    (line_rdwr),
    .line_addr    (line_addr),
    .line_wr_data (line_wr_data),
    .line_rd_data (line_rd_data)
  );

  sevseg_scan #(.SCAN_BITS(SCAN_BITS)) u_disp (
    .clk    (clk),
    .rst    (rst),
    .value  (disp_value),
    .an     (an),
    .a_to_g (a_to_g)
  );

endmodule

//--- verif/gemm_soc_tb.sv
`timescale 1ns/1ps

module gemm_soc_tb
  import soc_bus_pkg::*, gemm_pkg::*;
();

  localparam int        CLK_PERIOD  = 40;
  localparam int        SCAN_BITS   = 2;
  localparam int        NUM_CASES   = 4;
  localparam int        SEG_SAMPLES = 8 * (1 << SCAN_BITS) + 8;
  localparam bus_addr_t REG_BASE    = {GEMM_REGION, 28'h0};

  // Lit segments of the hex glyphs, a in bit 6
  localparam logic [6:0] GLYPH [16] = '{
    7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33, 7'h5b, 7'h5f, 7'h70,
    7'h7f, 7'h7b, 7'h77, 7'h1f, 7'h4e, 7'h3d, 7'h4f, 7'h47
  };

  typedef struct packed {
    bus_addr_t a_base;
    bus_addr_t b_base;
    bus_addr_t c_base;
    logic      use_rand; // Random matrices, else corner values
    bus_word_t disp;
  } gemm_case_t;

  logic       clk;
  logic       rst;
  logic       bus_en;
  logic       bus_rdwr;
  bus_addr_t  bus_addr;
  bus_word_t  bus_wr_data;
  byte_mask_t bus_mask;
  bus_word_t  bus_rd_data;
  logic [7:0] an;
  logic [6:0] a_to_g;

  gemm_case_t cases [NUM_CASES];
  elem_t      mat_a [mat_dim][mat_dim];
  elem_t      mat_b [mat_dim][mat_dim];
  int         seed = 32'h56cc_4d7a;
  int         errors;
  int         errors_at_start;
  int         tests_passed;
  int         tests_failed;

  gemm_soc #(.SCAN_BITS(SCAN_BITS)) dut0 (
    .clk         (clk),
    .rst         (rst),
    .bus_en      (bus_en),
    .bus_rdwr    (bus_rdwr),
    .bus_addr    (bus_addr),
    .bus_wr_data (bus_wr_data),
    .bus_mask    (bus_mask),
    .bus_rd_data (bus_rd_data),
    .an          (an),
    .a_to_g      (a_to_g)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(NUM_CASES * 400 * CLK_PERIOD);
    $display("timeout: run did not finish within %0d clock periods", NUM_CASES * 400);
    $display("TEST FAILED");
    $finish;
  end

  task automatic bus_write(input bus_addr_t addr, input bus_word_t data, input byte_mask_t mask);
    @(posedge clk);
    bus_en      <= 1'b1;
    bus_rdwr    <= 1'b1;
    bus_addr    <= addr;
    bus_wr_data <= data;
    bus_mask    <= mask;
    @(posedge clk);
    bus_en      <= 1'b0;
    bus_rdwr    <= 1'b0;
  endtask

  task automatic bus_read(input bus_addr_t addr, output bus_word_t data);
    @(posedge clk);
    bus_en   <= 1'b1;
    bus_rdwr <= 1'b0;
    bus_addr <= addr;
    @(posedge clk);
    bus_en   <= 1'b0;
    @(negedge clk); // Data registered on the strobe edge
    data = bus_rd_data;
  endtask

  task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_seg(input logic [2:0] digit, input logic [6:0] got,
                           input logic [6:0] exp);
    if (got !== exp) begin
      $display("mismatch a_to_g digit %0d: got %h expected %h", digit, got, exp);
      errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("error: %s", msg);
    errors++;
  endtask

  task automatic close_test(input string name);
    if (errors == errors_at_start) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail with %0d errors", name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  function automatic logic [6:0] seg_code(input logic [3:0] nibble);
    return ~GLYPH[nibble]; // Active-low
  endfunction

  function automatic bus_word_t ref_product(input int i, input int j);
    int sum;
    sum = 0;
    for (int k = 0; k < mat_dim; k++) begin
      sum += int'(mat_a[i][k]) * int'(mat_b[k][j]);
    end
    return bus_word_t'(sum);
  endfunction

  task automatic make_matrices(input logic use_rand);
    for (int i = 0; i < mat_dim; i++) begin
      for (int k = 0; k < mat_dim; k++) begin
        if (use_rand) begin
          mat_a[i][k] = elem_t'($random(seed));
          mat_b[i][k] = elem_t'($random(seed));
        end else begin
          mat_a[i][k] = ((i + k) % 2 == 1) ? 8'sh80 : 8'sh7f;
          mat_b[i][k] = (i == k) ? 8'sh80 : 8'shff;
        end
      end
    end
  endtask

  task automatic test_byte_masks();
    bus_addr_t addr;
    bus_word_t old_data, new_data, keep, got;
    for (int m = 0; m < 16; m++) begin
      addr     = 32'h0000_0200 + 4 * m;
      old_data = $random(seed);
      new_data = $random(seed);
      for (int b = 0; b < 4; b++) begin
        keep[8*b +: 8] = m[b] ? 8'h00 : 8'hff;
      end
      bus_write(addr, old_data, 4'hf);
      bus_write(addr, new_data, byte_mask_t'(m));
      bus_read(addr, got);
      check_word($sformatf("mem[%h] mask %h", addr, m), got,
                 (new_data & ~keep) | (old_data & keep));
    end
    close_test("byte masks");
  endtask

  task automatic test_registers();
    bus_word_t got;
    bus_read(REG_BASE + STATUS_OFS, got);
    check_word("status after reset", got, '0);
    bus_read(REG_BASE + DISP_OFS, got);
    check_word("disp after reset", got, '0);
    // A, B, C and DISP sit at consecutive words
    for (int r = 0; r < 4; r++) begin
      bus_write(REG_BASE + A_ADDR_OFS + 4 * r, 32'h1357_9bd0 + 32'h0101_0101 * r, 4'hf);
    end
    for (int r = 0; r < 4; r++) begin
      bus_read(REG_BASE + A_ADDR_OFS + 4 * r, got);
      check_word($sformatf("reg at offset %h", A_ADDR_OFS + 4 * r), got,
                 32'h1357_9bd0 + 32'h0101_0101 * r);
    end
    close_test("registers");
  endtask

  task automatic run_case(input int n);
    gemm_case_t c;
    bus_word_t  a_word, b_word, got;
    int         polls;
    c = cases[n];
    make_matrices(c.use_rand);
    for (int i = 0; i < mat_dim; i++) begin
      for (int k = 0; k < mat_dim; k++) begin
        a_word[8*k +: 8] = mat_a[i][k];
        b_word[8*k +: 8] = mat_b[i][k];
      end
      bus_write(c.a_base + 4 * i, a_word, 4'hf);
      bus_write(c.b_base + 4 * i, b_word, 4'hf);
    end
    for (int w = 0; w < mat_dim * mat_dim; w++) begin
      bus_write(c.c_base + 4 * w, (c.c_base + 4 * w) ^ 32'ha5a5_5a5a, 4'hf); // Stale fill
    end
    bus_write(REG_BASE + A_ADDR_OFS, c.a_base, 4'hf);
    bus_write(REG_BASE + B_ADDR_OFS, c.b_base, 4'hf);
    bus_write(REG_BASE + C_ADDR_OFS, c.c_base, 4'hf);
    bus_write(REG_BASE + CTRL_OFS, 32'h1, 4'hf);
    if (n % 2 == 1) begin
      bus_write(REG_BASE + CTRL_OFS, 32'h1, 4'hf); // Second start during the run
    end
    polls = 0;
    do begin
      bus_read(REG_BASE + STATUS_OFS, got);
      polls++;
    end while (got[STATUS_BUSY_BIT] && polls < 100);
    if (got[STATUS_BUSY_BIT]) begin
      report_error("accelerator still busy after 100 status polls");
    end
    check_word("status after run", got, 32'h2);
    for (int i = 0; i < mat_dim; i++) begin
      for (int j = 0; j < mat_dim; j++) begin
        bus_read(c.c_base + 16 * i + 4 * j, got);
        check_word($sformatf("case %0d C[%0d][%0d]", n, i, j), got, ref_product(i, j));
      end
    end
    close_test($sformatf("gemm case %0d", n));
  endtask

  task automatic check_display(input int n);
    bus_word_t  value;
    logic [7:0] seen;
    int         digit;
    value = cases[n].disp;
    seen  = '0;
    bus_write(REG_BASE + DISP_OFS, value, 4'hf);
    repeat (SEG_SAMPLES) begin
      @(negedge clk);
      digit = -1;
      for (int d = 0; d < 8; d++) begin
        if (an == ~(8'b1 << d)) digit = d;
      end
      if (digit < 0) begin
        report_error($sformatf("anode pattern %h is not one-hot low", an));
      end else begin
        seen[digit] = 1'b1;
        check_seg(3'(digit), a_to_g, seg_code(value[4*digit +: 4]));
      end
    end
    if (seen != 8'hff) begin
      report_error($sformatf("scan never reached some digits, seen mask %h", seen));
    end
    close_test($sformatf("display case %0d", n));
  endtask

  initial begin
    rst             = 1'b1;
    bus_en          = 1'b0;
    bus_rdwr        = 1'b0;
    bus_addr        = '0;
    bus_wr_data     = '0;
    bus_mask        = '0;
    errors          = 0;
    errors_at_start = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    cases[0] = '{32'h0000_0000, 32'h0000_0010, 32'h0000_0100, 1'b1, 32'h0123_4567};
    cases[1] = '{32'h0000_0400, 32'h0000_1230, 32'h0000_1f00, 1'b0, 32'h89ab_cdef};
    cases[2] = '{32'h0000_0800, 32'h0000_0040, 32'h0000_0c00, 1'b1, 32'hdead_beef};
    cases[3] = '{32'h0000_1ff0, 32'h0000_0000, 32'h0000_0ff0, 1'b1, 32'h5a5a_0f0f};
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    test_byte_masks();
    test_registers();
    for (int n = 0; n < NUM_CASES; n++) begin
      run_case(n);
      check_display(n);
    end
    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- gemm_soc.f
verilog/soc_bus_pkg.sv
verilog/gemm_pkg.sv
verilog/bus_router.sv
verilog/banked_mem.sv
verilog/gemm_regs.sv
verilog/gemm_row_mac.sv
verilog/gemm_ctrl.sv
verilog/sevseg_scan.sv
verilog/gemm_soc.sv
verif/gemm_soc_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TB_TOP     ?= gemm_soc_tb
RTL_TOP    ?= gemm_soc
FILELIST   ?= gemm_soc.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -qx 'TEST OK' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
